//--- verilog/ecc_pkg.sv
package ecc_pkg;

  // bus geometry
  localparam int amba_word       = 32;
  localparam int amba_addr_width = 20;

  // register offsets, decoded on paddr[3:0]
  localparam logic [3:0] ctrl_addr           = 4'h0;
  localparam logic [3:0] data_in_addr        = 4'h4;
  localparam logic [3:0] codeword_width_addr = 4'h8;
  localparam logic [3:0] noise_addr          = 4'hC;

  // ctrl[1:0]
  localparam logic [1:0] op_encode = 2'd0;
  localparam logic [1:0] op_decode = 2'd1;
  localparam logic [1:0] op_full   = 2'd2;

  // codeword_width[1:0]
  localparam logic [1:0] width_8  = 2'd0;
  localparam logic [1:0] width_16 = 2'd1;
  localparam logic [1:0] width_32 = 2'd2;

  // code geometry
  localparam int max_parity   = 5;
  localparam int core_latency = 3;
  localparam int cw_len_8     = 8;
  localparam int cw_len_16    = 16;
  localparam int cw_len_32    = 32;
  localparam int info_len_8   = 4;
  localparam int info_len_16  = 11;
  localparam int info_len_32  = 26;

  typedef enum logic [1:0] {
    apb_idle,
    apb_setup,
    apb_access
  } apb_phase_t;

  // width code 3 falls back to the 32-bit code
  function automatic int code_len(input logic [1:0] width_code);
    case (width_code)
      width_8:  return cw_len_8;
      width_16: return cw_len_16;
      default:  return cw_len_32;
    endcase
  endfunction

  function automatic int info_len(input logic [1:0] width_code);
    case (width_code)
      width_8:  return info_len_8;
      width_16: return info_len_16;
      default:  return info_len_32;
    endcase
  endfunction

  // bit 0 and the powers of two carry parity
  function automatic logic is_parity_pos(input int pos);
    return (pos == 0) || ((pos & (pos - 1)) == 0);
  endfunction

endpackage

//--- verilog/apb_regs.sv
`timescale 1ns/1ps

module apb_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [ecc_pkg::amba_addr_width-1:0] paddr,
  input  logic [ecc_pkg::amba_word-1:0]       pwdata,
  output logic [ecc_pkg::amba_word-1:0]       prdata,
  output logic                                start,
  output logic [ecc_pkg::amba_word-1:0]       ctrl,
  output logic [ecc_pkg::amba_word-1:0]       data_in,
  output logic [ecc_pkg::amba_word-1:0]       codeword_width,
  output logic [ecc_pkg::amba_word-1:0]       noise
);

  ecc_pkg::apb_phase_t phase;
  ecc_pkg::apb_phase_t phase_next;
  logic                access;
  logic                wr_en;
  logic                rd_en;
  logic [3:0]          offset;

  assign offset = paddr[3:0];

  // transfer completes on the access cycle right after a setup cycle
  assign access = (phase == ecc_pkg::apb_setup) && psel && penable;
  assign wr_en  = access && pwrite;
  assign rd_en  = access && !pwrite;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      phase <= ecc_pkg::apb_idle;
    end else begin
      phase <= phase_next;
    end
  end

  always_comb begin
    case (phase)
      ecc_pkg::apb_idle: begin
        if (psel && !penable) begin
          phase_next = ecc_pkg::apb_setup;
        end else begin
          phase_next = ecc_pkg::apb_idle;
        end
      end
      ecc_pkg::apb_setup: begin
        if (psel && penable) begin
          phase_next = ecc_pkg::apb_access;
        end else if (psel) begin
          phase_next = ecc_pkg::apb_setup;
        end else begin
          phase_next = ecc_pkg::apb_idle;
        end
      end
      ecc_pkg::apb_access: begin
        // back-to-back transfers go straight to a new setup
        if (psel && !penable) begin
          phase_next = ecc_pkg::apb_setup;
        end else begin
          phase_next = ecc_pkg::apb_idle;
        end
      end
      default: begin
        phase_next = ecc_pkg::apb_idle;
      end
    endcase
  end

  // register writes, unknown offsets dropped
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ctrl           <= '0;
      data_in        <= '0;
      codeword_width <= '0;
      noise          <= '0;
    end else if (wr_en) begin
      case (offset)
        ecc_pkg::ctrl_addr:           ctrl           <= pwdata;
        ecc_pkg::data_in_addr:        data_in        <= pwdata;
        ecc_pkg::codeword_width_addr: codeword_width <= pwdata;
        ecc_pkg::noise_addr:          noise          <= pwdata;
        default: ;
      endcase
    end
  end

  // one-cycle pulse after a ctrl write
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      start <= 1'b0;
    end else begin
      start <= wr_en && (offset == ecc_pkg::ctrl_addr);
    end
  end

  // read data held until the next read
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      prdata <= '0;
    end else if (rd_en) begin
      case (offset)
        ecc_pkg::ctrl_addr:           prdata <= ctrl;
        ecc_pkg::data_in_addr:        prdata <= data_in;
        ecc_pkg::codeword_width_addr: prdata <= codeword_width;
        ecc_pkg::noise_addr:          prdata <= noise;
        default:                      prdata <= '0;
      endcase
    end
  end

endmodule

//--- verilog/hamming_encoder.sv
`timescale 1ns/1ps

module hamming_encoder (
  input  logic [ecc_pkg::amba_word-1:0] info,
  input  logic [1:0]                    width_code,
  output logic [ecc_pkg::amba_word-1:0] codeword
);

  logic [ecc_pkg::amba_word-1:0] placed;
  logic [ecc_pkg::amba_word-1:0] with_parity;
  int                            code_w;
  int                            info_bits;

  assign code_w    = ecc_pkg::code_len(width_code);
  assign info_bits = ecc_pkg::info_len(width_code);

  // spread info bits over the data positions, lowest first
  always_comb begin
    int k;
    placed = '0;
    k = 0;
    for (int pos = 3; pos < ecc_pkg::amba_word; pos++) begin
      if (!ecc_pkg::is_parity_pos(pos)) begin
        if (k < info_bits) begin
          placed[pos] = info[k];
        end
        k++;
      end
    end
  end

  // parity bit at 2^j covers every index with bit j set
  always_comb begin
    logic p;
    with_parity = placed;
    for (int j = 0; j < ecc_pkg::max_parity; j++) begin
      p = 1'b0;
      for (int idx = 1; idx < ecc_pkg::amba_word; idx++) begin
        if ((idx & (1 << j)) != 0) begin
          p = p ^ placed[idx];
        end
      end
      if ((1 << j) < code_w) begin
        with_parity[1 << j] = p;
      end
    end
  end

  // overall parity closes the word for double-error detection
  assign codeword = {with_parity[ecc_pkg::amba_word-1:1], ^with_parity[ecc_pkg::amba_word-1:1]};

endmodule

//--- verilog/hamming_decoder.sv
`timescale 1ns/1ps

module hamming_decoder (
  input  logic [ecc_pkg::amba_word-1:0] received,
  input  logic [1:0]                    width_code,
  output logic [ecc_pkg::amba_word-1:0] info,
  output logic [1:0]                    num_of_errors
);

  logic [ecc_pkg::amba_word-1:0]  masked;
  logic [ecc_pkg::amba_word-1:0]  corrected;
  logic [ecc_pkg::max_parity-1:0] syndrome;
  logic                           overall;
  int                             code_w;

  assign code_w = ecc_pkg::code_len(width_code);

  // bits at and above the codeword width take no part
  always_comb begin
    for (int idx = 0; idx < ecc_pkg::amba_word; idx++) begin
      masked[idx] = (idx < code_w) ? received[idx] : 1'b0;
    end
  end

  always_comb begin
    syndrome = '0;
    for (int idx = 1; idx < ecc_pkg::amba_word; idx++) begin
      if (masked[idx]) begin
        syndrome = syndrome ^ idx[ecc_pkg::max_parity-1:0];
      end
    end
  end

  assign overall = ^masked;

  // odd overall check means a single flip, syndrome 0 is the parity bit itself
  always_comb begin
    corrected     = masked;
    num_of_errors = 2'd0;
    if (overall) begin
      corrected[syndrome] = ~masked[syndrome];
      num_of_errors       = 2'd1;
    end else if (syndrome != '0) begin
      num_of_errors = 2'd2;
    end
  end

  // pull the info bits back out, zero-extended
  always_comb begin
    int k;
    info = '0;
    k = 0;
    for (int pos = 3; pos < ecc_pkg::amba_word; pos++) begin
      if (!ecc_pkg::is_parity_pos(pos)) begin
        if (pos < code_w) begin
          info[k] = corrected[pos];
        end
        k++;
      end
    end
  end

endmodule

//--- verilog/ecc_core.sv
`timescale 1ns/1ps

module ecc_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic [ecc_pkg::amba_word-1:0] ctrl,
  input  logic [ecc_pkg::amba_word-1:0] data_in,
  input  logic [ecc_pkg::amba_word-1:0] codeword_width,
  input  logic [ecc_pkg::amba_word-1:0] noise,
  output logic [ecc_pkg::amba_word-1:0] data_out,
  output logic [1:0]                    num_of_errors,
  output logic                          operation_done
);

  logic [ecc_pkg::core_latency-1:0] valid_pipe;
  logic [1:0]                       start_op;
  logic [1:0]                       s1_op;
  logic [1:0]                       s1_width;
  logic [1:0]                       s2_op;
  logic [1:0]                       s2_width;
  logic [ecc_pkg::amba_word-1:0]    s1_data;
  logic [ecc_pkg::amba_word-1:0]    s1_noise;
  logic [ecc_pkg::amba_word-1:0]    s2_operand;
  logic [ecc_pkg::amba_word-1:0]    enc_codeword;
  logic [ecc_pkg::amba_word-1:0]    dec_info;
  logic [1:0]                       dec_errors;

  // op code 3 runs the full channel
  always_comb begin
    case (ctrl[1:0])
      ecc_pkg::op_encode: start_op = ecc_pkg::op_encode;
      ecc_pkg::op_decode: start_op = ecc_pkg::op_decode;
      default:            start_op = ecc_pkg::op_full;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[ecc_pkg::core_latency-2:0], start};
    end
  end

  hamming_encoder u_enc (
    .info       (s1_data),
    .width_code (s1_width),
    .codeword   (enc_codeword)
  );

  hamming_decoder u_dec (
    .received      (s2_operand),
    .width_code    (s2_width),
    .info          (dec_info),
    .num_of_errors (dec_errors)
  );

  // stage 1 capture, stage 2 operand select with noise injection
  always_ff @(posedge clk) begin
    if (start) begin
      s1_op    <= start_op;
      s1_width <= codeword_width[1:0];
      s1_data  <= data_in;
      s1_noise <= noise;
    end
    if (valid_pipe[0]) begin
      s2_op    <= s1_op;
      s2_width <= s1_width;
      case (s1_op)
        ecc_pkg::op_encode: s2_operand <= enc_codeword;
        ecc_pkg::op_decode: s2_operand <= s1_data;
        default:            s2_operand <= enc_codeword ^ s1_noise;
      endcase
    end
  end

  // stage 3 result, held until the next one
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      data_out      <= '0;
      num_of_errors <= 2'd0;
    end else if (valid_pipe[1]) begin
      if (s2_op == ecc_pkg::op_encode) begin
        data_out      <= s2_operand;
        num_of_errors <= 2'd0;
      end else begin
        data_out      <= dec_info;
        num_of_errors <= dec_errors;
      end
    end
  end

  assign operation_done = valid_pipe[ecc_pkg::core_latency-1];

endmodule

//--- verilog/ecc_top.sv
`timescale 1ns/1ps

module ecc_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [ecc_pkg::amba_addr_width-1:0] paddr,
  input  logic [ecc_pkg::amba_word-1:0]       pwdata,
  output logic [ecc_pkg::amba_word-1:0]       prdata,
  output logic [ecc_pkg::amba_word-1:0]       data_out,
  output logic [1:0]                          num_of_errors,
  output logic                                operation_done
);

  logic                          start;
  logic [ecc_pkg::amba_word-1:0] ctrl;
  logic [ecc_pkg::amba_word-1:0] data_in;
  logic [ecc_pkg::amba_word-1:0] codeword_width;
  logic [ecc_pkg::amba_word-1:0] noise;

  apb_regs u_regs (
    .clk            (clk),
    .rst            (rst),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .start          (start),
    .ctrl           (ctrl),
    .data_in        (data_in),
    .codeword_width (codeword_width),
    .noise          (noise)
  );

  ecc_core u_core (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .ctrl           (ctrl),
    .data_in        (data_in),
    .codeword_width (codeword_width),
    .noise          (noise),
    .data_out       (data_out),
    .num_of_errors  (num_of_errors),
    .operation_done (operation_done)
  );

endmodule

//--- tests/ecc_properties.sv
`timescale 1ns/1ps

module ecc_properties (
  input logic       clk,
  input logic       rst,
  input logic       start,
  input logic       operation_done,
  input logic [1:0] num_of_errors
);

  int error_count = 0;

  // start is a single-cycle pulse
  start_one_cycle: assert property (@(posedge clk) disable iff (!rst) start |=> !start)
    else begin
      $error("start stayed high for more than one cycle");
      error_count++;
    end

  // done comes exactly core_latency cycles after each start, also for back-to-back starts
  done_after_start: assert property (@(posedge clk) disable iff (!rst)
    operation_done == $past(start, ecc_pkg::core_latency))
    else begin
      $error("operation_done does not follow start by the core latency");
      error_count++;
    end

  reset_quiet: assert property (@(posedge clk) !rst |-> !operation_done && !start)
    else begin
      $error("operation_done or start high during reset");
      error_count++;
    end

  errors_in_range: assert property (@(posedge clk) disable iff (!rst) num_of_errors != 2'd3)
    else begin
      $error("num_of_errors reached 3");
      error_count++;
    end

endmodule

bind ecc_top ecc_properties u_props (
  .clk            (clk),
  .rst            (rst),
  .start          (start),
  .operation_done (operation_done),
  .num_of_errors  (num_of_errors)
);

//--- tests/ecc_tb.sv
`timescale 1ns/1ps

module ecc_tb;

  localparam int reset_cycles = 8;
  localparam int mix_ops      = 16;
  // register test, eight operations per width, a back-to-back pair, random mix
  localparam int total_ops    = 10 + 3 * 8 + 2 + mix_ops;

  logic                                clk = 1'b0;
  logic                                rst;
  logic                                psel;
  logic                                penable;
  logic                                pwrite;
  logic [ecc_pkg::amba_addr_width-1:0] paddr;
  logic [ecc_pkg::amba_word-1:0]       pwdata;
  logic [ecc_pkg::amba_word-1:0]       prdata;
  logic [ecc_pkg::amba_word-1:0]       data_out;
  logic [1:0]                          num_of_errors;
  logic                                operation_done;

  logic [31:0] lfsr_state = 32'he2b1;
  logic [31:0] exp_data_q[$];
  logic [1:0]  exp_errs_q[$];

  ecc_top dut (
    .clk            (clk),
    .rst            (rst),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .data_out       (data_out),
    .num_of_errors  (num_of_errors),
    .operation_done (operation_done)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end else begin
      return s >> 1;
    end
  endfunction

  // one lfsr step per bit with the first bit taken at the lsb
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = galois_step(lfsr_state);
      r[i] = lfsr_state[0];
    end
    return r;
  endfunction

  function automatic int width_bits(input logic [1:0] wcode);
    case (wcode)
      2'd0:    return 8;
      2'd1:    return 16;
      default: return 32;
    endcase
  endfunction

  function automatic int info_count(input logic [1:0] wcode);
    case (wcode)
      2'd0:    return 4;
      2'd1:    return 11;
      default: return 26;
    endcase
  endfunction

  function automatic logic [4:0] rand_pos(input logic [1:0] wcode);
    logic [31:0] r;
    r = rand_bits($clog2(width_bits(wcode)));
    return r[4:0];
  endfunction

  // parity bits are set to cancel the syndrome of the placed data
  function automatic logic [31:0] encode_model(input logic [31:0] info, input logic [1:0] wcode);
    logic [31:0] cw;
    logic [4:0]  s;
    int          w;
    int          k;
    w = width_bits(wcode);
    cw = '0;
    s = '0;
    k = 0;
    for (int pos = 3; pos < w; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        cw[pos] = info[k];
        k++;
      end
    end
    for (int pos = 1; pos < w; pos++) begin
      if (cw[pos]) s = s ^ pos[4:0];
    end
    for (int b = 0; b < 5; b++) begin
      if ((1 << b) < w) cw[1 << b] = s[b];
    end
    cw[0] = ^cw[31:1];
    return cw;
  endfunction

  // result is {error count, info bits}
  function automatic logic [33:0] decode_model(input logic [31:0] rx, input logic [1:0] wcode);
    logic [31:0] cw;
    logic [31:0] info;
    logic [4:0]  s;
    logic [1:0]  errs;
    int          w;
    int          k;
    w = width_bits(wcode);
    cw = '0;
    s = '0;
    for (int pos = 0; pos < w; pos++) begin
      cw[pos] = rx[pos];
      if (pos > 0 && rx[pos]) s = s ^ pos[4:0];
    end
    errs = 2'd0;
    if (^cw) begin
      cw[s] = ~cw[s];
      errs = 2'd1;
    end else if (s != '0) begin
      errs = 2'd2;
    end
    info = '0;
    k = 0;
    for (int pos = 3; pos < w; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        info[k] = cw[pos];
        k++;
      end
    end
    return {errs, info};
  endfunction

  function automatic void expect_result(input logic [1:0] op, input logic [31:0] data,
                                        input logic [1:0] wcode, input logic [31:0] nz);
    logic [33:0] dec;
    if (op == 2'd0) begin
      exp_data_q.push_back(encode_model(data, wcode));
      exp_errs_q.push_back(2'd0);
    end else begin
      if (op == 2'd1) dec = decode_model(data, wcode);
      else dec = decode_model(encode_model(data, wcode) ^ nz, wcode);
      exp_data_q.push_back(dec[31:0]);
      exp_errs_q.push_back(dec[33:32]);
    end
  endfunction

  task automatic halt_run;
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Fail at %0t: %s = %h, expected %h", $time, name, got, want);
    halt_run();
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    halt_run();
  endtask

  // leaves psel high so a following call makes a back-to-back transfer
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= {16'h0, addr};
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
  endtask

  task automatic bus_idle;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= {16'h0, addr};
    @(posedge clk);
    penable <= 1'b1;
    bus_idle();
    @(negedge clk);
    data = prdata;
  endtask

  task automatic wait_results;
    while (exp_data_q.size() != 0) @(posedge clk);
  endtask

  task automatic run_op(input logic [1:0] op, input logic [31:0] data,
                        input logic [1:0] wcode, input logic [31:0] nz);
    expect_result(op, data, wcode, nz);
    apb_write(ecc_pkg::data_in_addr, data);
    apb_write(ecc_pkg::codeword_width_addr, {30'd0, wcode});
    apb_write(ecc_pkg::noise_addr, nz);
    apb_write(ecc_pkg::ctrl_addr, {30'd0, op});
    bus_idle();
    wait_results();
  endtask

  task automatic check_registers;
    logic [3:0]  offs [4];
    logic [31:0] vals [4];
    logic [31:0] got;
    offs = '{ecc_pkg::data_in_addr, ecc_pkg::codeword_width_addr,
             ecc_pkg::noise_addr, ecc_pkg::ctrl_addr};
    for (int i = 0; i < 4; i++) begin
      vals[i] = rand_bits(32);
    end
    // ctrl goes last and starts an operation on the other three
    expect_result(vals[3][1:0], vals[0], vals[1][1:0], vals[2]);
    for (int i = 0; i < 4; i++) begin
      apb_write(offs[i], vals[i]);
    end
    bus_idle();
    for (int i = 0; i < 4; i++) begin
      apb_read(offs[i], got);
      assert (got == vals[i]) else report_mismatch("prdata", got, vals[i]);
    end
    apb_read(4'h6, got);
    assert (got == '0) else report_mismatch("prdata", got, '0);
    wait_results();
  endtask

  task automatic run_width(input logic [1:0] wcode);
    logic [31:0] info;
    logic [31:0] cw;
    logic [4:0]  p1;
    logic [4:0]  p2;
    for (int i = 0; i < 2; i++) begin
      info = rand_bits(info_count(wcode));
      run_op(ecc_pkg::op_encode, info, wcode, '0);
    end
    info = rand_bits(info_count(wcode));
    cw = encode_model(info, wcode);
    run_op(ecc_pkg::op_decode, cw, wcode, '0);
    run_op(ecc_pkg::op_decode, cw ^ 32'h1, wcode, '0);
    p1 = rand_pos(wcode);
    run_op(ecc_pkg::op_decode, cw ^ (32'h1 << p1), wcode, '0);
    // flipping bit 0 of the index keeps the second position distinct and in range
    p2 = p1 ^ 5'd1;
    run_op(ecc_pkg::op_full, info, wcode, '0);
    run_op(ecc_pkg::op_full, info, wcode, 32'h1 << p1);
    run_op(ecc_pkg::op_full, info, wcode, (32'h1 << p1) | (32'h1 << p2));
  endtask

  task automatic run_back_to_back;
    logic [31:0] info;
    logic [31:0] nz;
    info = rand_bits(11);
    nz = 32'h1 << rand_pos(2'd1);
    // the two in-flight operations differ so a stage mix-up shows in the results
    expect_result(ecc_pkg::op_full, info, ecc_pkg::width_16, nz);
    expect_result(ecc_pkg::op_encode, info, ecc_pkg::width_16, nz);
    apb_write(ecc_pkg::data_in_addr, info);
    apb_write(ecc_pkg::codeword_width_addr, {30'd0, ecc_pkg::width_16});
    apb_write(ecc_pkg::noise_addr, nz);
    apb_write(ecc_pkg::ctrl_addr, {30'd0, ecc_pkg::op_full});
    apb_write(ecc_pkg::ctrl_addr, {30'd0, ecc_pkg::op_encode});
    bus_idle();
    wait_results();
  endtask

  always @(negedge clk) begin
    logic [31:0] want_data;
    logic [1:0]  want_errs;
    if (rst && operation_done) begin
      if (exp_data_q.size() == 0) begin
        report_problem("operation_done came with no operation outstanding");
      end else begin
        want_data = exp_data_q.pop_front();
        want_errs = exp_errs_q.pop_front();
        assert (data_out == want_data) else report_mismatch("data_out", data_out, want_data);
        assert (num_of_errors == want_errs)
          else report_mismatch("num_of_errors", {30'd0, num_of_errors}, {30'd0, want_errs});
      end
    end
  end

  always @(negedge clk) begin
    if (dut.u_props.error_count != 0) begin
      report_problem("a timing property of the DUT failed");
    end
  end

  initial begin
    #((reset_cycles + total_ops * 20) * 10);
    report_problem("timeout: the tests did not finish in the expected time");
  end

  initial begin
    logic [31:0] r;
    logic [1:0]  op;
    logic [1:0]  wc;
    rst     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b1;
    check_registers();
    for (int w = 0; w < 3; w++) begin
      run_width(w[1:0]);
    end
    run_back_to_back();
    // op and width codes 3 come up here too
    for (int i = 0; i < mix_ops; i++) begin
      r = rand_bits(2);
      op = r[1:0];
      r = rand_bits(2);
      wc = r[1:0];
      run_op(op, rand_bits(32), wc, rand_bits(32) & rand_bits(32) & rand_bits(32));
    end
    repeat (4) @(posedge clk);
    if (dut.u_props.error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      report_problem("a timing property of the DUT failed");
    end
  end

endmodule

//--- tb.f
verilog/ecc_pkg.sv
verilog/apb_regs.sv
verilog/hamming_encoder.sv
verilog/hamming_decoder.sv
verilog/ecc_core.sv
verilog/ecc_top.sv
tests/ecc_properties.sv
tests/ecc_tb.sv

//--- Makefile
TOP = ecc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

obj_dir/V$(TOP): tb.f verilog/*.sv tests/*.sv
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
